// File: include/dcache_config.svh
`ifndef DCACHE_CONFIG_SVH
`define DCACHE_CONFIG_SVH

// address and word widths
`define DC_ADDR_W      32
`define DC_XLEN        64

// geometry, two ways of 64 sets
`define DC_SETS        64
`define DC_INDEX_W     6
`define DC_OFFSET_W    5
`define DC_TAG_W       21

// a line is four words
`define DC_LINE_WORDS  4
`define DC_LINE_W      256

`endif

// File: hdl/dcache_pkg.sv
`default_nettype none
`include "dcache_config.svh"

package dcache_pkg;

  typedef enum logic {
    opLoad  = 1'b0,
    opStore = 1'b1
  } cacheOp_e;

  // request as seen on the cpu port
  typedef struct packed {
    cacheOp_e                  op;
    logic [`DC_ADDR_W-1:0]     addr;
    logic [`DC_XLEN-1:0]       wdata;
    logic [`DC_XLEN/8-1:0]     mask;
  } cpuReq_t;

  // one word per memory transaction
  typedef struct packed {
    logic                      isWrite;
    logic [`DC_ADDR_W-1:0]     addr;
    logic [`DC_XLEN-1:0]       wdata;
  } memReq_t;

  typedef enum logic [2:0] {
    stIdle      = 3'd0,
    stLookup    = 3'd1,
    stWriteBack = 3'd2,
    stRefill    = 3'd3,
    stInstall   = 3'd4,
    stDone      = 3'd5
  } ctrlState_e;

  // line address, offset bits dropped
  typedef struct packed {
    logic [`DC_TAG_W-1:0]      tag;
    logic [`DC_INDEX_W-1:0]    index;
  } lineAddr_t;

endpackage

`default_nettype wire

// File: hdl/tag_store.sv
`timescale 1ns/1ps
`default_nettype none
`include "dcache_config.svh"

module tag_store (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic [`DC_INDEX_W-1:0]    index_i,
  input  logic [`DC_TAG_W-1:0]      tag_i,
  input  logic                      tagWrite_i,
  input  logic                      tagWay_i,
  input  logic                      markDirty_i,
  input  logic                      touch_i,
  output logic                      hit_o,
  output logic                      hitWay_o,
  output logic                      victimWay_o,
  output logic                      victimDirty_o,
  output logic [`DC_TAG_W-1:0]      victimTag_o
);

  logic [`DC_TAG_W-1:0]        tagArr [2][`DC_SETS];
  logic [1:0][`DC_SETS-1:0]    validArr;
  logic [1:0][`DC_SETS-1:0]    dirtyArr;
  // lru bit names the way to evict next
  logic [`DC_SETS-1:0]         lruArr;
  logic [1:0]                  wayHit;

  always_comb begin
    for (int w = 0; w < 2; w++) begin
      wayHit[w] = validArr[w][index_i] && (tagArr[w][index_i] == tag_i);
    end
  end

  assign hit_o    = |wayHit;
  assign hitWay_o = wayHit[1];

  // an empty way is filled before anything is evicted
  always_comb begin
    if (!validArr[0][index_i]) begin
      victimWay_o = 1'b0;
    end else if (!validArr[1][index_i]) begin
      victimWay_o = 1'b1;
    end else begin
      victimWay_o = lruArr[index_i];
    end
  end

  assign victimDirty_o = validArr[victimWay_o][index_i] && dirtyArr[victimWay_o][index_i];
  assign victimTag_o   = tagArr[victimWay_o][index_i];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      validArr <= '0;
      dirtyArr <= '0;
      lruArr   <= '0;
    end else begin
      if (tagWrite_i) begin
        validArr[tagWay_i][index_i] <= 1'b1;
        dirtyArr[tagWay_i][index_i] <= 1'b0;
      end else if (markDirty_i) begin
        dirtyArr[tagWay_i][index_i] <= 1'b1;
      end
      if (touch_i) begin
        lruArr[index_i] <= ~tagWay_i;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (tagWrite_i) begin
      tagArr[tagWay_i][index_i] <= tag_i;
    end
  end

endmodule

`default_nettype wire

// File: hdl/data_store.sv
`timescale 1ns/1ps
`default_nettype none
`include "dcache_config.svh"

module data_store (
  input  logic                      clk,
  input  logic                      we_i,
  input  logic                      way_i,
  input  logic [`DC_INDEX_W-1:0]    index_i,
  input  logic                      lineWrite_i,
  input  logic [1:0]                wordSel_i,
  input  logic [`DC_LINE_W-1:0]     fillLine_i,
  input  logic [`DC_XLEN-1:0]       storeData_i,
  input  logic [`DC_XLEN/8-1:0]     storeMask_i,
  output logic [`DC_XLEN-1:0]       rdWord_o,
  output logic [`DC_LINE_W-1:0]     victimLine_o
);

  logic [`DC_LINE_W-1:0] lineArr [2][`DC_SETS];
  logic [`DC_LINE_W-1:0] curLine;
  logic [`DC_LINE_W-1:0] mergedLine;

  assign curLine = lineArr[way_i][index_i];

  // byte lanes of the selected word
  always_comb begin
    mergedLine = curLine;
    for (int b = 0; b < `DC_XLEN/8; b++) begin
      if (storeMask_i[b]) begin
        mergedLine[wordSel_i*`DC_XLEN + b*8 +: 8] = storeData_i[b*8 +: 8];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (we_i) begin
      lineArr[way_i][index_i] <= lineWrite_i ? fillLine_i : mergedLine;
    end
    // read returns the contents before this cycle's write
    rdWord_o     <= curLine[wordSel_i*`DC_XLEN +: `DC_XLEN];
    victimLine_o <= curLine;
  end

endmodule

`default_nettype wire

// File: hdl/refill_engine.sv
`timescale 1ns/1ps
`default_nettype none
`include "dcache_config.svh"

module refill_engine (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      start_i,
  input  dcache_pkg::lineAddr_t     addr_i,
  output logic                      done_o,
  output logic [`DC_LINE_W-1:0]     line_o,
  output logic                      memReq_o,
  output dcache_pkg::memReq_t       memReqData_o,
  input  logic                      memAck_i,
  input  logic [`DC_XLEN-1:0]       memRdata_i
);
  import dcache_pkg::*;

  lineAddr_t  addrQ;
  logic       busy;
  logic [1:0] beat;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy     <= 1'b0;
      beat     <= '0;
      memReq_o <= 1'b0;
      done_o   <= 1'b0;
    end else begin
      done_o <= 1'b0;
      if (start_i && !busy) begin
        busy     <= 1'b1;
        beat     <= '0;
        memReq_o <= 1'b1;
      end else if (busy) begin
        if (memReq_o && memAck_i) begin
          memReq_o <= 1'b0;
        end else if (!memReq_o && !memAck_i) begin
          // ack is back low, next beat or finish
          if (beat == 2'd3) begin
            busy   <= 1'b0;
            done_o <= 1'b1;
          end else begin
            beat     <= beat + 2'd1;
            memReq_o <= 1'b1;
          end
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start_i && !busy) begin
      addrQ <= addr_i;
    end
    if (busy && memReq_o && memAck_i) begin
      line_o[beat*`DC_XLEN +: `DC_XLEN] <= memRdata_i;
    end
  end

  always_comb begin
    memReqData_o.isWrite = 1'b0;
    memReqData_o.addr    = {addrQ.tag, addrQ.index, beat, 3'b000};
    memReqData_o.wdata   = '0;
  end

endmodule

`default_nettype wire

// File: hdl/writeback_engine.sv
`timescale 1ns/1ps
`default_nettype none
`include "dcache_config.svh"

module writeback_engine (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      start_i,
  input  dcache_pkg::lineAddr_t     addr_i,
  input  logic [`DC_LINE_W-1:0]     line_i,
  output logic                      done_o,
  output logic                      memReq_o,
  output dcache_pkg::memReq_t       memReqData_o,
  input  logic                      memAck_i
);
  import dcache_pkg::*;

  lineAddr_t              addrQ;
  logic [`DC_LINE_W-1:0]  lineQ;
  logic                   busy;
  logic [1:0]             beat;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy     <= 1'b0;
      beat     <= '0;
      memReq_o <= 1'b0;
      done_o   <= 1'b0;
    end else begin
      done_o <= 1'b0;
      if (start_i && !busy) begin
        busy     <= 1'b1;
        beat     <= '0;
        memReq_o <= 1'b1;
      end else if (busy) begin
        if (memReq_o && memAck_i) begin
          memReq_o <= 1'b0;
        end else if (!memReq_o && !memAck_i) begin
          if (beat == 2'd3) begin
            busy   <= 1'b0;
            done_o <= 1'b1;
          end else begin
            beat     <= beat + 2'd1;
            memReq_o <= 1'b1;
          end
        end
      end
    end
  end

  // victim copy taken at start, the data store moves on
  always_ff @(posedge clk) begin
    if (start_i && !busy) begin
      addrQ <= addr_i;
      lineQ <= line_i;
    end
  end

  always_comb begin
    memReqData_o.isWrite = 1'b1;
    memReqData_o.addr    = {addrQ.tag, addrQ.index, beat, 3'b000};
    memReqData_o.wdata   = lineQ[beat*`DC_XLEN +: `DC_XLEN];
  end

endmodule

`default_nettype wire

// File: hdl/mem_arbiter.sv
`timescale 1ns/1ps
`default_nettype none
`include "dcache_config.svh"

module mem_arbiter (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  wbReq_i,
  input  dcache_pkg::memReq_t   wbReqData_i,
  input  logic                  rfReq_i,
  input  dcache_pkg::memReq_t   rfReqData_i,
  output logic                  wbAck_o,
  output logic                  rfAck_o,
  output logic [`DC_XLEN-1:0]   rdata_o,
  output logic                  memReq_o,
  output dcache_pkg::memReq_t   memReqData_o,
  input  logic                  memAck_i,
  input  logic [`DC_XLEN-1:0]   memRdata_i
);

  logic granted;
  logic ownerWb;
  logic ownerReq;

  assign ownerReq = ownerWb ? wbReq_i : rfReq_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      granted <= 1'b0;
      ownerWb <= 1'b0;
    end else if (!granted) begin
      // write-back wins a tie
      if (wbReq_i || rfReq_i) begin
        granted <= 1'b1;
        ownerWb <= wbReq_i;
      end
    end else if (!ownerReq && !memAck_i) begin
      granted <= 1'b0;
    end
  end

  assign memReq_o     = granted && ownerReq;
  assign memReqData_o = ownerWb ? wbReqData_i : rfReqData_i;
  assign wbAck_o      = granted && ownerWb && memAck_i;
  assign rfAck_o      = granted && !ownerWb && memAck_i;
  assign rdata_o      = memRdata_i;

endmodule

`default_nettype wire

// File: hdl/cache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none
`include "dcache_config.svh"

module cache_ctrl (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      cpuReq_i,
  input  dcache_pkg::cpuReq_t       cpuReqData_i,
  output logic                      cpuAck_o,
  output logic [`DC_XLEN-1:0]       cpuRdata_o,
  // tag store side
  input  logic                      hit_i,
  input  logic                      hitWay_i,
  input  logic                      victimWay_i,
  input  logic                      victimDirty_i,
  input  logic [`DC_TAG_W-1:0]      victimTag_i,
  output logic                      tagWrite_o,
  output logic                      tagWay_o,
  output logic [`DC_INDEX_W-1:0]    index_o,
  output logic [`DC_TAG_W-1:0]      tag_o,
  output logic                      markDirty_o,
  output logic                      touch_o,
  // data store side
  input  logic [`DC_XLEN-1:0]       rdWord_i,
  input  logic [`DC_LINE_W-1:0]     victimLine_i,
  output logic                      dataWe_o,
  output logic                      dataWay_o,
  output logic                      lineWrite_o,
  output logic [1:0]                wordSel_o,
  output logic [`DC_XLEN-1:0]       storeData_o,
  output logic [`DC_XLEN/8-1:0]     storeMask_o,
  output logic [`DC_LINE_W-1:0]     fillLine_o,
  // engines
  output logic                      wbStart_o,
  input  logic                      wbDone_i,
  output dcache_pkg::lineAddr_t     wbAddr_o,
  output logic [`DC_LINE_W-1:0]     wbLine_o,
  output logic                      rfStart_o,
  input  logic                      rfDone_i,
  output dcache_pkg::lineAddr_t     rfAddr_o,
  input  logic [`DC_LINE_W-1:0]     rfLine_i
);
  import dcache_pkg::*;

  ctrlState_e state;
  cpuReq_t    reqQ;
  logic       wayQ;
  logic       lookupWay;
  logic       isLookup;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= stIdle;
      cpuAck_o  <= 1'b0;
      wbStart_o <= 1'b0;
      rfStart_o <= 1'b0;
    end else begin
      wbStart_o <= 1'b0;
      rfStart_o <= 1'b0;
      case (state)
        stIdle: begin
          if (cpuReq_i) begin
            state <= stLookup;
          end
        end
        stLookup: begin
          if (hit_i) begin
            state    <= stDone;
            cpuAck_o <= 1'b1;
          end else if (victimDirty_i) begin
            state     <= stWriteBack;
            wbStart_o <= 1'b1;
          end else begin
            state     <= stRefill;
            rfStart_o <= 1'b1;
          end
        end
        stWriteBack: begin
          // refill always follows the write-back
          if (wbDone_i) begin
            state     <= stRefill;
            rfStart_o <= 1'b1;
          end
        end
        stRefill: begin
          if (rfDone_i) begin
            state <= stInstall;
          end
        end
        stInstall: state <= stLookup;
        stDone: begin
          if (!cpuReq_i) begin
            state    <= stIdle;
            cpuAck_o <= 1'b0;
          end
        end
        default: state <= stIdle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == stIdle && cpuReq_i) begin
      reqQ <= cpuReqData_i;
    end
    // victim way and address are frozen for the whole miss
    if (state == stLookup) begin
      wayQ           <= lookupWay;
      wbAddr_o.tag   <= victimTag_i;
      wbAddr_o.index <= index_o;
    end
  end

  assign isLookup  = (state == stLookup);
  assign lookupWay = hit_i ? hitWay_i : victimWay_i;
  assign tagWay_o  = isLookup ? lookupWay : wayQ;
  assign dataWay_o = tagWay_o;

  // address split of the latched request
  assign tag_o     = reqQ.addr[`DC_ADDR_W-1 -: `DC_TAG_W];
  assign index_o   = reqQ.addr[`DC_OFFSET_W +: `DC_INDEX_W];
  assign wordSel_o = reqQ.addr[`DC_OFFSET_W-1:3];

  assign touch_o     = isLookup && hit_i;
  assign markDirty_o = touch_o && (reqQ.op == opStore);
  assign tagWrite_o  = (state == stInstall);
  assign lineWrite_o = tagWrite_o;
  assign dataWe_o    = tagWrite_o || markDirty_o;

  assign storeData_o = reqQ.wdata;
  assign storeMask_o = reqQ.mask;
  assign fillLine_o  = rfLine_i;
  assign wbLine_o    = victimLine_i;
  assign rfAddr_o    = '{tag: tag_o, index: index_o};

  // stores answer with zero
  assign cpuRdata_o = (cpuAck_o && reqQ.op == opLoad) ? rdWord_i : '0;

endmodule

`default_nettype wire

// File: hdl/dcache_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "dcache_config.svh"

module dcache_top (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  cpuReq_i,
  input  dcache_pkg::cpuReq_t   cpuReqData_i,
  output logic                  cpuAck_o,
  output logic [`DC_XLEN-1:0]   cpuRdata_o,
  output logic                  memReq_o,
  output dcache_pkg::memReq_t   memReqData_o,
  input  logic                  memAck_i,
  input  logic [`DC_XLEN-1:0]   memRdata_i
);
  import dcache_pkg::*;

  // tag store wires
  logic                     hit, hitWay, victimWay, victimDirty;
  logic [`DC_TAG_W-1:0]     victimTag, tag;
  logic [`DC_INDEX_W-1:0]   index;
  logic                     tagWrite, tagWay, markDirty, touch;

  // data store wires
  logic [`DC_XLEN-1:0]      rdWord, storeData;
  logic [`DC_LINE_W-1:0]    victimLine, fillLine;
  logic                     dataWe, dataWay, lineWrite;
  logic [1:0]               wordSel;
  logic [`DC_XLEN/8-1:0]    storeMask;

  // engines and memory side
  logic                     wbStart, wbDone, rfStart, rfDone;
  lineAddr_t                wbAddr, rfAddr;
  logic [`DC_LINE_W-1:0]    wbLine, rfLine;
  logic                     wbMemReq, wbMemAck, rfMemReq, rfMemAck;
  memReq_t                  wbMemData, rfMemData;
  logic [`DC_XLEN-1:0]      arbRdata;

  cache_ctrl ctrlInst (
    .clk, .rst_n, .cpuReq_i, .cpuReqData_i, .cpuAck_o, .cpuRdata_o,
    .hit_i(hit), .hitWay_i(hitWay), .victimWay_i(victimWay),
    .victimDirty_i(victimDirty), .victimTag_i(victimTag),
    .tagWrite_o(tagWrite), .tagWay_o(tagWay), .index_o(index), .tag_o(tag),
    .markDirty_o(markDirty), .touch_o(touch),
    .rdWord_i(rdWord), .victimLine_i(victimLine), .dataWe_o(dataWe),
    .dataWay_o(dataWay), .lineWrite_o(lineWrite), .wordSel_o(wordSel),
    .storeData_o(storeData), .storeMask_o(storeMask), .fillLine_o(fillLine),
    .wbStart_o(wbStart), .wbDone_i(wbDone), .wbAddr_o(wbAddr), .wbLine_o(wbLine),
    .rfStart_o(rfStart), .rfDone_i(rfDone), .rfAddr_o(rfAddr), .rfLine_i(rfLine)
  );

  tag_store tagInst (
    .clk, .rst_n, .index_i(index), .tag_i(tag), .tagWrite_i(tagWrite),
    .tagWay_i(tagWay), .markDirty_i(markDirty), .touch_i(touch),
    .hit_o(hit), .hitWay_o(hitWay), .victimWay_o(victimWay),
    .victimDirty_o(victimDirty), .victimTag_o(victimTag)
  );

  data_store dataInst (
    .clk, .we_i(dataWe), .way_i(dataWay), .index_i(index), .lineWrite_i(lineWrite),
    .wordSel_i(wordSel), .fillLine_i(fillLine), .storeData_i(storeData),
    .storeMask_i(storeMask), .rdWord_o(rdWord), .victimLine_o(victimLine)
  );

  refill_engine refillInst (
    .clk, .rst_n, .start_i(rfStart), .addr_i(rfAddr), .done_o(rfDone), .line_o(rfLine),
    .memReq_o(rfMemReq), .memReqData_o(rfMemData), .memAck_i(rfMemAck),
    .memRdata_i(arbRdata)
  );

  writeback_engine wbInst (
    .clk, .rst_n, .start_i(wbStart), .addr_i(wbAddr), .line_i(wbLine), .done_o(wbDone),
    .memReq_o(wbMemReq), .memReqData_o(wbMemData), .memAck_i(wbMemAck)
  );

  mem_arbiter arbInst (
    .clk, .rst_n, .wbReq_i(wbMemReq), .wbReqData_i(wbMemData), .rfReq_i(rfMemReq),
    .rfReqData_i(rfMemData), .wbAck_o(wbMemAck), .rfAck_o(rfMemAck), .rdata_o(arbRdata),
    .memReq_o, .memReqData_o, .memAck_i, .memRdata_i
  );

endmodule

`default_nettype wire

// File: verif/dcache_assert.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_assert (
  input logic                 clk,
  input logic                 rst_n,
  input logic                 cpuReq_i,
  input logic                 cpuAck_o,
  input logic                 memReq_o,
  input dcache_pkg::memReq_t  memReqData_o,
  input logic                 memAck_i
);

  int failCount = 0;

  // ack is only up while the request is up or was up one cycle ago
  ackNeedsReq: assert property (
    @(posedge clk) disable iff (!rst_n)
    cpuAck_o |-> (cpuReq_i || $past(cpuReq_i))
  ) else begin
    failCount++;
    $error("cpu ack raised without a request");
  end

  // address and data hold until memory answers
  memDataStable: assert property (
    @(posedge clk) disable iff (!rst_n)
    (memReq_o && !memAck_i) |=> (!memReq_o || $stable(memReqData_o))
  ) else begin
    failCount++;
    $error("memory request changed before ack");
  end

  ackDropsAfterReq: assert property (
    @(posedge clk) disable iff (!rst_n)
    (!cpuReq_i && cpuAck_o) |=> !cpuAck_o
  ) else begin
    failCount++;
    $error("cpu ack held after request dropped");
  end

endmodule

bind dcache_top dcache_assert assertInst (
  .clk(clk), .rst_n(rst_n), .cpuReq_i(cpuReq_i), .cpuAck_o(cpuAck_o),
  .memReq_o(memReq_o), .memReqData_o(memReqData_o), .memAck_i(memAck_i)
);

`default_nettype wire

// File: verif/tb_dcache.sv
`timescale 1ns/1ps
`default_nettype none
`include "dcache_config.svh"

module tb_dcache;
  import dcache_pkg::*;

  localparam int CLK_PERIOD = 20;
  localparam int ACK_DELAY  = 2;
  localparam int ROW_CYCLES = 200;

  typedef struct packed {
    cacheOp_e                op;
    logic [`DC_ADDR_W-1:0]   addr;
    logic [`DC_XLEN-1:0]     wdata;
    logic [`DC_XLEN/8-1:0]   mask;
    logic [3:0]              expWrites;
    logic [3:0]              expReads;
  } testRow_t;

  logic                  clk;
  logic                  rst_n;
  logic                  cpuReq;
  cpuReq_t               cpuReqData;
  logic                  cpuAck;
  logic [`DC_XLEN-1:0]   cpuRdata;
  logic                  memReq;
  memReq_t               memReqData;
  logic                  memAck;
  logic [`DC_XLEN-1:0]   memRdata;

  integer                seed;
  logic                  tableReady;
  testRow_t              rows[$];
  logic [`DC_XLEN-1:0]   initArr [logic [`DC_ADDR_W-1:0]];
  logic [`DC_XLEN-1:0]   backArr [logic [`DC_ADDR_W-1:0]];
  logic [`DC_XLEN-1:0]   goldArr [logic [`DC_ADDR_W-1:0]];
  int                    memWrites = 0;
  int                    memReads = 0;
  int                    ackWait;

  dcache_top dcache_inst (
    .clk(clk), .rst_n(rst_n), .cpuReq_i(cpuReq), .cpuReqData_i(cpuReqData),
    .cpuAck_o(cpuAck), .cpuRdata_o(cpuRdata), .memReq_o(memReq),
    .memReqData_o(memReqData), .memAck_i(memAck), .memRdata_i(memRdata)
  );

  always #(CLK_PERIOD/2) clk = ~clk;

  // first touch of a word draws a value mixed with its address
  function automatic logic [`DC_XLEN-1:0] initialWord(input logic [`DC_ADDR_W-1:0] addr);
    logic [`DC_XLEN-1:0] val;
    if (!initArr.exists(addr)) begin
      val = {$random(seed), $random(seed)};
      initArr[addr] = val ^ {addr, ~addr};
    end
    return initArr[addr];
  endfunction

  function automatic logic [`DC_XLEN-1:0] goldRead(input logic [`DC_ADDR_W-1:0] addr);
    return goldArr.exists(addr) ? goldArr[addr] : initialWord(addr);
  endfunction

  function automatic logic [`DC_XLEN-1:0] backRead(input logic [`DC_ADDR_W-1:0] addr);
    return backArr.exists(addr) ? backArr[addr] : initialWord(addr);
  endfunction

  function automatic logic [`DC_ADDR_W-1:0] makeAddr(input logic [`DC_TAG_W-1:0] tag,
      input logic [`DC_INDEX_W-1:0] index, input logic [1:0] word);
    return {tag, index, word, 3'b000};
  endfunction

  task automatic goldStore(input logic [`DC_ADDR_W-1:0] addr,
      input logic [`DC_XLEN-1:0] data, input logic [`DC_XLEN/8-1:0] mask);
    logic [`DC_XLEN-1:0] word;
    word = goldRead(addr);
    for (int b = 0; b < `DC_XLEN/8; b++) begin
      if (mask[b]) begin
        word[b*8 +: 8] = data[b*8 +: 8];
      end
    end
    goldArr[addr] = word;
  endtask

  task automatic checkEq(input logic [63:0] actual, input logic [63:0] expected,
      input string what);
    if (actual !== expected) begin
      $display("FAIL at %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
      $display("FAIL: see errors above");
      $fatal(1, "mismatch in %s", what);
    end
  endtask

  task automatic addRow(input cacheOp_e op, input logic [`DC_ADDR_W-1:0] addr,
      input logic [`DC_XLEN-1:0] wdata, input logic [`DC_XLEN/8-1:0] mask,
      input int writes, input int reads);
    rows.push_back('{op: op, addr: addr, wdata: wdata, mask: mask,
                     expWrites: writes[3:0], expReads: reads[3:0]});
  endtask

  task automatic buildTable();
    // miss in set 3 followed by hits on other words and a partial store
    addRow(opLoad,  makeAddr(21'h00100, 6'd3, 2'd1), '0, '0, 0, 4);
    addRow(opLoad,  makeAddr(21'h00100, 6'd3, 2'd3), '0, '0, 0, 0);
    addRow(opLoad,  makeAddr(21'h00100, 6'd3, 2'd0), '0, '0, 0, 0);
    addRow(opStore, makeAddr(21'h00100, 6'd3, 2'd2), 64'hdeadbeef_cafef00d, 8'h3c, 0, 0);
    addRow(opLoad,  makeAddr(21'h00100, 6'd3, 2'd2), '0, '0, 0, 0);
    // in set 21 C evicts clean B after A B A
    addRow(opLoad,  makeAddr(21'h00012, 6'd21, 2'd0), '0, '0, 0, 4);
    addRow(opLoad,  makeAddr(21'h00034, 6'd21, 2'd1), '0, '0, 0, 4);
    addRow(opLoad,  makeAddr(21'h00012, 6'd21, 2'd2), '0, '0, 0, 0);
    addRow(opLoad,  makeAddr(21'h00056, 6'd21, 2'd3), '0, '0, 0, 4);
    addRow(opLoad,  makeAddr(21'h00012, 6'd21, 2'd1), '0, '0, 0, 0);
    // dirty A becomes the victim of D
    addRow(opStore, makeAddr(21'h00012, 6'd21, 2'd1), 64'h0123_4567_89ab_cdef, 8'hf0, 0, 0);
    addRow(opLoad,  makeAddr(21'h00056, 6'd21, 2'd0), '0, '0, 0, 0);
    addRow(opLoad,  makeAddr(21'h00078, 6'd21, 2'd2), '0, '0, 4, 4);
    addRow(opLoad,  makeAddr(21'h00012, 6'd21, 2'd1), '0, '0, 0, 4);
    addRow(opLoad,  makeAddr(21'h00078, 6'd21, 2'd0), '0, '0, 0, 0);
    addRow(opLoad,  makeAddr(21'h00056, 6'd21, 2'd3), '0, '0, 0, 4);
    addRow(opStore, makeAddr(21'h00100, 6'd3, 2'd2), 64'h5a5a_a5a5_0f0f_f0f0, 8'hff, 0, 0);
    addRow(opLoad,  makeAddr(21'h00100, 6'd3, 2'd2), '0, '0, 0, 0);
  endtask

  // memory model answers one word per four-phase transaction
  always @(posedge clk) begin
    if (!rst_n) begin
      memAck   <= 1'b0;
      memRdata <= '0;
      ackWait  <= 0;
    end else if (memReq && !memAck) begin
      if (ackWait == ACK_DELAY) begin
        ackWait <= 0;
        memAck  <= 1'b1;
        if (memReqData.isWrite) begin
          backArr[memReqData.addr] = memReqData.wdata;
          memWrites++;
        end else begin
          memRdata <= backRead(memReqData.addr);
          memReads++;
        end
      end else begin
        ackWait <= ackWait + 1;
      end
    end else if (!memReq && memAck) begin
      memAck <= 1'b0;
    end
  end

  always @(dcache_inst.assertInst.failCount) begin
    if (dcache_inst.assertInst.failCount != 0) begin
      $display("ERROR: a protocol assertion failed at %0t ns", $time);
      $display("FAIL: see errors above");
      $fatal(1, "assertion failure");
    end
  end

  initial begin
    testRow_t            row;
    logic [`DC_XLEN-1:0] expData;
    int                  writes0;
    int                  reads0;
    seed       = 32'h6905;
    tableReady = 1'b0;
    clk        = 1'b0;
    rst_n      = 1'b0;
    cpuReq     = 1'b0;
    cpuReqData = '0;
    memAck     = 1'b0;
    memRdata   = '0;
    buildTable();
    tableReady = 1'b1;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    foreach (rows[i]) begin
      row     = rows[i];
      writes0 = memWrites;
      reads0  = memReads;
      cpuReq     <= 1'b1;
      cpuReqData <= '{op: row.op, addr: row.addr, wdata: row.wdata, mask: row.mask};
      if (row.op == opStore) begin
        expData = '0;
        goldStore(row.addr, row.wdata, row.mask);
      end else begin
        expData = goldRead(row.addr);
      end
      do @(posedge clk); while (!cpuAck);
      checkEq(cpuRdata, expData, $sformatf("row %0d read data", i));
      checkEq(memWrites - writes0, row.expWrites, $sformatf("row %0d memory writes", i));
      checkEq(memReads - reads0, row.expReads, $sformatf("row %0d memory reads", i));
      cpuReq <= 1'b0;
      do @(posedge clk); while (cpuAck);
    end
    $display("PASS: all tests");
    $finish;
  end

  // generous budget per table row
  initial begin
    wait (tableReady);
    repeat (rows.size() * ROW_CYCLES + 8) @(posedge clk);
    $display("ERROR: timeout at %0t ns, the cache stopped answering", $time);
    $display("FAIL: see errors above");
    $fatal(1, "watchdog timeout");
  end

endmodule

`default_nettype wire

// File: dcacheProj.f
+incdir+include
hdl/dcache_pkg.sv
hdl/tag_store.sv
hdl/data_store.sv
hdl/refill_engine.sv
hdl/writeback_engine.sv
hdl/mem_arbiter.sv
hdl/cache_ctrl.sv
hdl/dcache_top.sv
verif/dcache_assert.sv
verif/tb_dcache.sv

// File: Bender.yml
package:
  name: dcache_proj

sources:
  - include_dirs:
      - include
    files:
      - hdl/dcache_pkg.sv
      - hdl/tag_store.sv
      - hdl/data_store.sv
      - hdl/refill_engine.sv
      - hdl/writeback_engine.sv
      - hdl/mem_arbiter.sv
      - hdl/cache_ctrl.sv
      - hdl/dcache_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - verif/dcache_assert.sv
      - verif/tb_dcache.sv
